/* hw/igr_types_pkg.sv */
// ====================
// Frame word layout, header field positions
// and the classifier action encoding
// ====================

package igr_types_pkg;

  // ====================
  // Frame word
  // ====================

  // One lane word, 64 bits
  localparam int data_w = 64;

  // ====================
  // First word header fields
  // ====================

  // Destination address, upper 48 bits of the sop word
  localparam int dmac_hi = 63;
  localparam int dmac_lo = 16;
  localparam int dmac_w  = dmac_hi - dmac_lo + 1;

  // Ethertype, low 16 bits of the sop word
  localparam int etype_hi = 15;
  localparam int etype_lo = 0;
  localparam int etype_w  = etype_hi - etype_lo + 1;

  // ====================
  // Port and class widths
  // ====================

  // Port number, enough for up to 8 lanes
  localparam int port_w = 3;

  // Traffic class
  localparam int tc_w = 2;

  // ====================
  // Classifier action
  // ====================

  // Per frame decision, held from sop to eop
  typedef enum logic [1:0] {
    act_forward = 2'd0,
    act_flood   = 2'd1,
    act_drop    = 2'd2
  } igr_action_e;

endpackage

/* hw/igr_csr_pkg.sv */
// ====================
// Register map, reset values and field widths
// ====================

package igr_csr_pkg;

  // Wishbone word address and data widths
  localparam int adr_w = 3;
  localparam int csr_w = 32;

  // ====================
  // Register addresses
  // ====================
  localparam logic [adr_w-1:0] reg_ctrl       = 3'd0;
  localparam logic [adr_w-1:0] reg_drop_etype = 3'd1;
  localparam logic [adr_w-1:0] reg_tc_map     = 3'd2;
  // Read only frame counters
  localparam logic [adr_w-1:0] reg_fwd_count  = 3'd3;
  localparam logic [adr_w-1:0] reg_drop_count = 3'd4;

  // ====================
  // Reset values
  // ====================
  localparam logic [csr_w-1:0] ctrl_rst       = 32'h0000_0000;
  localparam logic [csr_w-1:0] drop_etype_rst = 32'h0000_0000;
  localparam logic [csr_w-1:0] tc_map_rst     = 32'h0000_0000;

  // ====================
  // Field positions and widths
  // ====================
  // reg_ctrl enable bit
  localparam int ingress_en_bit = 0;
  // reg_drop_etype: ethertype in 15:0, rule enable in 16
  localparam int etype_fld_w    = 16;
  localparam int drop_en_bit    = 16;
  // reg_tc_map: bits per source port
  localparam int tc_map_fld_w   = 2;

endpackage

/* hw/igr_port_arb.sv */
// ====================
// Round-robin arbiter over the receive lanes,
// locked to one lane from sop to eop
// ====================

module igr_port_arb import igr_types_pkg::*; #(
  parameter int NUM_PORTS = 5
) (
  input  logic                        ingress_clock,
  input  logic                        arst_n,
  // Receive lanes
  input  logic [NUM_PORTS-1:0]        rx_valid,
  output logic [NUM_PORTS-1:0]        rx_ready,
  input  logic [NUM_PORTS-1:0]        rx_sop,
  input  logic [NUM_PORTS-1:0]        rx_eop,
  input  logic [NUM_PORTS*data_w-1:0] rx_data,
  // Configuration
  input  logic                        ingress_en,
  // Stream to the parser
  output logic                        s1_valid,
  input  logic                        s1_ready,
  output logic [data_w-1:0]           s1_data,
  output logic                        s1_sop,
  output logic                        s1_eop,
  output logic [port_w-1:0]           s1_src_port
);

  // Grant state, grant_idx doubles as the last served lane
  logic              locked;
  logic [port_w-1:0] grant_idx;
  // Next candidate lane
  logic              pick_vld;
  logic [port_w-1:0] pick_idx;
  // Output register free or draining this cycle
  logic              load;
  // Word moves from the granted lane
  logic              take;

  // ====================
  // Round-robin pick
  // ====================
  // Search starts one past the last grant, nearest lane wins
  always_comb begin
    int idx;
    pick_vld = 1'b0;
    pick_idx = '0;
    for (int k = NUM_PORTS; k >= 1; k--) begin
      idx = (int'(grant_idx) + k) % NUM_PORTS;
      // Only a lane waiting with a frame start is a candidate
      if (rx_valid[idx] && rx_sop[idx]) begin
        pick_vld = 1'b1;
        pick_idx = port_w'(idx);
      end
    end
  end

  assign load = !s1_valid || s1_ready;
  assign take = locked && rx_valid[grant_idx] && load;

  // Ready only towards the granted lane
  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      rx_ready[i] = locked && load && (grant_idx == port_w'(i));
    end
  end

  // ====================
  // Grant lock
  // ====================
  always_ff @(posedge ingress_clock or negedge arst_n) begin
    if (!arst_n) begin
      locked    <= 1'b0;
      // Lane 0 is first after reset
      grant_idx <= port_w'(NUM_PORTS - 1);
    end else if (!locked) begin
      // New grants only while enabled
      if (ingress_en && pick_vld) begin
        locked    <= 1'b1;
        grant_idx <= pick_idx;
      end
    end else if (take && rx_eop[grant_idx]) begin
      // Release once eop has moved
      locked <= 1'b0;
    end
  end

  // ====================
  // Output register
  // ====================
  always_ff @(posedge ingress_clock or negedge arst_n) begin
    if (!arst_n) begin
      s1_valid <= 1'b0;
    end else if (load) begin
      s1_valid <= take;
    end
  end

  always_ff @(posedge ingress_clock) begin
    if (take) begin
      s1_data     <= rx_data[int'(grant_idx)*data_w +: data_w];
      s1_sop      <= rx_sop[grant_idx];
      s1_eop      <= rx_eop[grant_idx];
      s1_src_port <= grant_idx;
    end
  end

endmodule

/* hw/igr_parser.sv */
// ====================
// Header parser stage, pulls address and ethertype
// from the sop word and holds them for the frame
// ====================

module igr_parser import igr_types_pkg::*; (
  input  logic               ingress_clock,
  input  logic               arst_n,
  // Stream from the arbiter
  input  logic               s1_valid,
  output logic               s1_ready,
  input  logic [data_w-1:0]  s1_data,
  input  logic               s1_sop,
  input  logic               s1_eop,
  input  logic [port_w-1:0]  s1_src_port,
  // Stream to the classifier
  output logic               s2_valid,
  input  logic               s2_ready,
  output logic [data_w-1:0]  s2_data,
  output logic               s2_sop,
  output logic               s2_eop,
  output logic [port_w-1:0]  s2_src_port,
  // Header fields, valid with every word of the frame
  output logic [dmac_w-1:0]  s2_dmac,
  output logic [etype_w-1:0] s2_etype
);

  // Output register free or draining
  logic load;
  // Word accepted from the arbiter
  logic take;

  assign load     = !s2_valid || s2_ready;
  assign take     = s1_valid && load;
  assign s1_ready = load;

  // ====================
  // Valid flag
  // ====================
  always_ff @(posedge ingress_clock or negedge arst_n) begin
    if (!arst_n) begin
      s2_valid <= 1'b0;
    end else if (load) begin
      s2_valid <= s1_valid;
    end
  end

  // ====================
  // Data path
  // ====================
  // Words pass through unchanged
  always_ff @(posedge ingress_clock) begin
    if (take) begin
      s2_data     <= s1_data;
      s2_sop      <= s1_sop;
      s2_eop      <= s1_eop;
      s2_src_port <= s1_src_port;
    end
  end

  // Field capture on sop only
  // Later words of the frame keep the captured values
  always_ff @(posedge ingress_clock) begin
    if (take && s1_sop) begin
      s2_dmac  <= s1_data[dmac_hi:dmac_lo];
      s2_etype <= s1_data[etype_hi:etype_lo];
    end
  end

endmodule

/* hw/igr_classifier.sv */
// ====================
// Frame classifier, action, destination and class,
// removes dropped frames from the stream
// ====================

module igr_classifier import igr_types_pkg::*; #(
  parameter int NUM_PORTS = 5
) (
  input  logic                      ingress_clock,
  input  logic                      arst_n,
  // Stream from the parser
  input  logic                      s2_valid,
  output logic                      s2_ready,
  input  logic [data_w-1:0]         s2_data,
  input  logic                      s2_sop,
  input  logic                      s2_eop,
  input  logic [port_w-1:0]         s2_src_port,
  input  logic [dmac_w-1:0]         s2_dmac,
  input  logic [etype_w-1:0]        s2_etype,
  // Configuration
  input  logic [etype_w-1:0]        drop_etype,
  input  logic                      drop_en,
  input  logic [NUM_PORTS*tc_w-1:0] tc_map,
  // Egress stream
  output logic                      tx_valid,
  input  logic                      tx_ready,
  output logic [data_w-1:0]         tx_data,
  output logic                      tx_sop,
  output logic                      tx_eop,
  output logic [port_w-1:0]         tx_src_port,
  output logic [port_w-1:0]         tx_dst_port,
  output logic [tc_w-1:0]           tx_tc,
  output igr_action_e               tx_action,
  // Frame count events
  output logic                      fwd_pulse,
  output logic                      drop_pulse
);

  // Decision from the sop header
  igr_action_e       dec_action;
  logic [port_w-1:0] dec_dst;
  logic [tc_w-1:0]   dec_tc;
  // Decision held for the rest of the frame
  igr_action_e       hold_action;
  logic [port_w-1:0] hold_dst;
  logic [tc_w-1:0]   hold_tc;
  // Decision applied to the current word
  igr_action_e       cur_action;
  logic [port_w-1:0] cur_dst;
  logic [tc_w-1:0]   cur_tc;
  logic              load;
  logic              take;

  // ====================
  // Rules, in priority order
  // ====================
  always_comb begin
    dec_dst = '0;
    if (drop_en && (s2_etype == drop_etype)) begin
      dec_action = act_drop;
    end else if (&s2_dmac) begin
      // Broadcast goes out on port 0 flagged as flood
      dec_action = act_flood;
    end else if (int'(s2_dmac[port_w-1:0]) >= NUM_PORTS) begin
      dec_action = act_drop;
    end else begin
      dec_action = act_forward;
      dec_dst    = s2_dmac[port_w-1:0];
    end
    dec_tc = tc_map[int'(s2_src_port)*tc_w +: tc_w];
  end

  // Fresh decision at sop, held one after
  assign cur_action = s2_sop ? dec_action : hold_action;
  assign cur_dst    = s2_sop ? dec_dst    : hold_dst;
  assign cur_tc     = s2_sop ? dec_tc     : hold_tc;

  assign load     = !tx_valid || tx_ready;
  assign take     = s2_valid && load;
  assign s2_ready = load;

  always_ff @(posedge ingress_clock or negedge arst_n) begin
    if (!arst_n) begin
      hold_action <= act_forward;
    end else if (take && s2_sop) begin
      hold_action <= dec_action;
    end
  end

  always_ff @(posedge ingress_clock) begin
    if (take && s2_sop) begin
      hold_dst <= dec_dst;
      hold_tc  <= dec_tc;
    end
  end

  // ====================
  // Output register
  // ====================
  // Dropped words are consumed without a tx valid
  always_ff @(posedge ingress_clock or negedge arst_n) begin
    if (!arst_n) begin
      tx_valid <= 1'b0;
    end else if (load) begin
      tx_valid <= take && (cur_action != act_drop);
    end
  end

  always_ff @(posedge ingress_clock) begin
    if (take) begin
      tx_data     <= s2_data;
      tx_sop      <= s2_sop;
      tx_eop      <= s2_eop;
      tx_src_port <= s2_src_port;
      tx_dst_port <= cur_dst;
      tx_tc       <= cur_tc;
      tx_action   <= cur_action;
    end
  end

  // Count events on the eop word
  assign fwd_pulse  = tx_valid && tx_ready && tx_eop;
  assign drop_pulse = take && s2_eop && (cur_action == act_drop);

endmodule

/* hw/igr_csr.sv */
// ====================
// Wishbone classic register slave,
// control registers and frame counters
// ====================

module igr_csr import igr_csr_pkg::*; #(
  parameter int NUM_PORTS = 5
) (
  input  logic                              ingress_clock,
  input  logic                              arst_n,
  // Wishbone classic slave
  input  logic                              wb_cyc,
  input  logic                              wb_stb,
  input  logic                              wb_we,
  input  logic [adr_w-1:0]                  wb_adr,
  input  logic [csr_w-1:0]                  wb_dat_w,
  output logic [csr_w-1:0]                  wb_dat_r,
  output logic                              wb_ack,
  // Count events from the classifier
  input  logic                              fwd_pulse,
  input  logic                              drop_pulse,
  // Configuration out
  output logic                              ingress_en,
  output logic [etype_fld_w-1:0]            drop_etype,
  output logic                              drop_en,
  output logic [NUM_PORTS*tc_map_fld_w-1:0] tc_map
);

  // Request seen, not yet acked
  logic             req;
  logic             wr;
  logic [csr_w-1:0] fwd_count;
  logic [csr_w-1:0] drop_count;
  logic [csr_w-1:0] rd_mux;

  assign req = wb_cyc && wb_stb && !wb_ack;
  assign wr  = req && wb_we;

  // ====================
  // Handshake and read data
  // ====================
  always_ff @(posedge ingress_clock or negedge arst_n) begin
    if (!arst_n) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= req;
    end
  end

  // Unused addresses read zero
  always_comb begin
    rd_mux = '0;
    case (wb_adr)
      reg_ctrl: rd_mux[ingress_en_bit] = ingress_en;
      reg_drop_etype: begin
        rd_mux[etype_fld_w-1:0] = drop_etype;
        rd_mux[drop_en_bit]     = drop_en;
      end
      reg_tc_map:     rd_mux[NUM_PORTS*tc_map_fld_w-1:0] = tc_map;
      reg_fwd_count:  rd_mux = fwd_count;
      reg_drop_count: rd_mux = drop_count;
      default:        rd_mux = '0;
    endcase
  end

  // Held for the ack cycle
  always_ff @(posedge ingress_clock) begin
    if (req) begin
      wb_dat_r <= rd_mux;
    end
  end

  // ====================
  // Writable registers
  // ====================
  // Writes to counters or unused addresses fall through
  always_ff @(posedge ingress_clock or negedge arst_n) begin
    if (!arst_n) begin
      ingress_en <= ctrl_rst[ingress_en_bit];
      drop_etype <= drop_etype_rst[etype_fld_w-1:0];
      drop_en    <= drop_etype_rst[drop_en_bit];
      tc_map     <= tc_map_rst[NUM_PORTS*tc_map_fld_w-1:0];
    end else if (wr) begin
      case (wb_adr)
        reg_ctrl: ingress_en <= wb_dat_w[ingress_en_bit];
        reg_drop_etype: begin
          drop_etype <= wb_dat_w[etype_fld_w-1:0];
          drop_en    <= wb_dat_w[drop_en_bit];
        end
        reg_tc_map: tc_map <= wb_dat_w[NUM_PORTS*tc_map_fld_w-1:0];
        default: ;
      endcase
    end
  end

  // Frame counters, wrap at 32 bits
  always_ff @(posedge ingress_clock or negedge arst_n) begin
    if (!arst_n) begin
      fwd_count  <= '0;
      drop_count <= '0;
    end else begin
      if (fwd_pulse) fwd_count <= fwd_count + 1'b1;
      if (drop_pulse) drop_count <= drop_count + 1'b1;
    end
  end

endmodule

/* hw/igr_top.sv */
// ====================
// Ingress top, arbiter, parser, classifier
// and register block
// ====================

module igr_top import igr_types_pkg::*; import igr_csr_pkg::*; #(
  parameter int NUM_PORTS = 5
) (
  input  logic                        ingress_clock,
  input  logic                        arst_n,
  // Receive lanes
  input  logic [NUM_PORTS-1:0]        rx_valid,
  output logic [NUM_PORTS-1:0]        rx_ready,
  input  logic [NUM_PORTS-1:0]        rx_sop,
  input  logic [NUM_PORTS-1:0]        rx_eop,
  input  logic [NUM_PORTS*data_w-1:0] rx_data,
  // Egress stream
  output logic                        tx_valid,
  input  logic                        tx_ready,
  output logic [data_w-1:0]           tx_data,
  output logic                        tx_sop,
  output logic                        tx_eop,
  output logic [port_w-1:0]           tx_src_port,
  output logic [port_w-1:0]           tx_dst_port,
  output logic [tc_w-1:0]             tx_tc,
  output igr_action_e                 tx_action,
  // Register port
  input  logic                        wb_cyc,
  input  logic                        wb_stb,
  input  logic                        wb_we,
  input  logic [adr_w-1:0]            wb_adr,
  input  logic [csr_w-1:0]            wb_dat_w,
  output logic [csr_w-1:0]            wb_dat_r,
  output logic                        wb_ack
);

  // Configuration
  logic                        ingress_en;
  logic [etype_w-1:0]          drop_etype;
  logic                        drop_en;
  logic [NUM_PORTS*tc_w-1:0]   tc_map;
  // Arbiter to parser
  logic                        s1_valid, s1_ready, s1_sop, s1_eop;
  logic [data_w-1:0]           s1_data;
  logic [port_w-1:0]           s1_src_port;
  // Parser to classifier
  logic                        s2_valid, s2_ready, s2_sop, s2_eop;
  logic [data_w-1:0]           s2_data;
  logic [port_w-1:0]           s2_src_port;
  logic [dmac_w-1:0]           s2_dmac;
  logic [etype_w-1:0]          s2_etype;
  // Count events
  logic                        fwd_pulse, drop_pulse;

  igr_port_arb #(.NUM_PORTS(NUM_PORTS)) u_arb (.*);

  igr_parser u_parser (.*);

  igr_classifier #(.NUM_PORTS(NUM_PORTS)) u_cls (.*);

  igr_csr #(.NUM_PORTS(NUM_PORTS)) u_csr (.*);

endmodule

/* verif/igr_tb.sv */
// ====================
// Ingress testbench, lane drivers, reference model,
// scoreboard and register checks
// ====================

module igr_tb import igr_types_pkg::*, igr_csr_pkg::*; ();

  localparam int NUM_PORTS   = 5;
  localparam int DRAIN_LIMIT = 3000;

  // Expected classifier result for one frame
  typedef struct packed {
    igr_action_e       action;
    logic [port_w-1:0] dst;
    logic [tc_w-1:0]   tc;
  } verdict_t;

  typedef struct packed {
    logic              sop;
    logic              eop;
    logic [data_w-1:0] data;
  } lane_word_t;

  typedef struct packed {
    lane_word_t w;
    verdict_t   v;
  } exp_word_t;

  logic                        ingress_clock;
  logic                        arst_n;
  logic [NUM_PORTS-1:0]        rx_valid, rx_ready, rx_sop, rx_eop;
  logic [NUM_PORTS*data_w-1:0] rx_data;
  logic                        tx_valid, tx_ready, tx_sop, tx_eop;
  logic [data_w-1:0]           tx_data;
  logic [port_w-1:0]           tx_src_port, tx_dst_port;
  logic [tc_w-1:0]             tx_tc;
  igr_action_e                 tx_action;
  logic                        wb_cyc, wb_stb, wb_we, wb_ack;
  logic [adr_w-1:0]            wb_adr;
  logic [csr_w-1:0]            wb_dat_w, wb_dat_r;

  // Words waiting on each lane, and words expected on tx per source
  lane_word_t lane_q[NUM_PORTS][$];
  exp_word_t  exp_q[NUM_PORTS][$];

  integer           seed = 44934;
  integer           ready_seed = 44934;
  logic             random_ready = 1'b0;
  // Shadow copies of the writable registers
  logic [csr_w-1:0] sh_ctrl = '0;
  logic [csr_w-1:0] sh_drop = '0;
  logic [csr_w-1:0] sh_tc = '0;
  int               fwd_exp = 0;
  int               drop_exp = 0;
  int               mismatches = 0;
  int               failures = 0;
  int               words_checked = 0;
  // Scoreboard state
  logic             held;
  logic [75:0]      held_bundle;
  logic             in_frame;
  logic [port_w-1:0] frame_src;

  igr_top #(.NUM_PORTS(NUM_PORTS)) DUT (.*);

  initial begin
    ingress_clock = 1'b0;
    forever #20 ingress_clock = ~ingress_clock;
  end

  // ====================
  // Reference model
  // ====================
  // Classifier rules in priority order
  function automatic verdict_t igr_expect(input logic [data_w-1:0] first, input int src,
                                          input logic [csr_w-1:0] drop_reg,
                                          input logic [csr_w-1:0] tc_reg);
    verdict_t    r;
    logic [47:0] da;
    logic [15:0] et;
    da       = first[63:16];
    et       = first[15:0];
    r.dst    = '0;
    r.tc     = tc_reg[2*src +: 2];
    r.action = act_forward;
    if (drop_reg[16] && (et == drop_reg[15:0])) begin
      r.action = act_drop;
    end else if (da == 48'hffff_ffff_ffff) begin
      r.action = act_flood;
    end else if (da[2:0] >= NUM_PORTS) begin
      r.action = act_drop;
    end else begin
      r.dst = da[2:0];
    end
    return r;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond) else begin
      $display("Error: %s", what);
      failures++;
    end
  endtask

  // ====================
  // Stimulus helpers
  // ====================
  function automatic logic [47:0] random_addr(input logic [2:0] low);
    logic [63:0] r;
    r = {$random(seed), $random(seed)};
    return {r[47:3], low};
  endfunction

  // Header with a random address and now and then the drop ethertype
  function automatic logic [data_w-1:0] random_first();
    logic [15:0] et;
    et = (($random(seed) & 3) == 0) ? 16'h88cc : 16'($random(seed));
    return {random_addr(3'($random(seed))), et};
  endfunction

  function automatic int frame_len();
    return 1 + ($unsigned($random(seed)) % 6);
  endfunction

  task automatic send_frame(input int port, input int len, input logic [data_w-1:0] first);
    verdict_t   v;
    lane_word_t w;
    exp_word_t  e;
    v = igr_expect(first, port, sh_drop, sh_tc);
    for (int i = 0; i < len; i++) begin
      w.sop  = (i == 0);
      w.eop  = (i == len - 1);
      w.data = (i == 0) ? first : {$random(seed), $random(seed)};
      lane_q[port].push_back(w);
      e.w = w;
      e.v = v;
      if (v.action != act_drop) exp_q[port].push_back(e);
    end
    if (v.action == act_drop) drop_exp++;
    else fwd_exp++;
  endtask

  // Single Wishbone classic cycle that waits for ack
  task automatic wb_access(input logic we, input logic [adr_w-1:0] adr,
                           input logic [csr_w-1:0] wdat, output logic [csr_w-1:0] rdat);
    int n;
    @(posedge ingress_clock);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= wdat;
    n = 0;
    do begin
      @(posedge ingress_clock);
      n++;
    end while (!wb_ack && n < 20);
    rdat = wb_dat_r;
    check_true(wb_ack, $sformatf("no ack from register address %0d", adr));
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wb_write(input logic [adr_w-1:0] adr, input logic [csr_w-1:0] data);
    logic [csr_w-1:0] unused;
    wb_access(1'b1, adr, data, unused);
    if (adr == reg_ctrl) sh_ctrl = data;
    if (adr == reg_drop_etype) sh_drop = data;
    if (adr == reg_tc_map) sh_tc = data;
  endtask

  task automatic wb_read(input logic [adr_w-1:0] adr, output logic [csr_w-1:0] data);
    wb_access(1'b0, adr, '0, data);
  endtask

  // Wait until every lane is empty and every expected word has left
  task automatic wait_drain();
    int n;
    bit busy;
    n    = 0;
    busy = 1'b1;
    while (busy && n < DRAIN_LIMIT) begin
      @(negedge ingress_clock);
      n++;
      busy = 1'b0;
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (lane_q[p].size() != 0 || exp_q[p].size() != 0) busy = 1'b1;
      end
    end
    // Frames that never arrived per source
    for (int p = 0; p < NUM_PORTS; p++) begin
      int lost;
      lost = 0;
      for (int i = 0; i < exp_q[p].size(); i++) begin
        if (exp_q[p][i].w.sop) lost++;
      end
      check_true(!busy || (lost == 0 && lane_q[p].size() == 0),
                 $sformatf("port %0d: %0d frames never arrived", p, lost));
      exp_q[p].delete();
      lane_q[p].delete();
    end
    // Pipeline depth plus counter update
    repeat (6) @(negedge ingress_clock);
  endtask

  task automatic check_counters();
    logic [csr_w-1:0] rd;
    wb_read(reg_fwd_count, rd);
    check_value("reg_fwd_count", rd, fwd_exp);
    wb_read(reg_drop_count, rd);
    check_value("reg_drop_count", rd, drop_exp);
  endtask

  // ====================
  // Lane drivers and tx_ready
  // ====================
  always @(posedge ingress_clock) begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (rx_valid[p] && rx_ready[p]) lane_q[p].delete(0);
      if (lane_q[p].size() > 0) begin
        rx_valid[p]                  <= 1'b1;
        rx_sop[p]                    <= lane_q[p][0].sop;
        rx_eop[p]                    <= lane_q[p][0].eop;
        rx_data[p*data_w +: data_w]  <= lane_q[p][0].data;
      end else begin
        rx_valid[p] <= 1'b0;
      end
    end
    if (random_ready) tx_ready <= (($random(ready_seed) & 3) != 0);
    else tx_ready <= 1'b1;
  end

  // ====================
  // Scoreboard
  // ====================
  always @(posedge ingress_clock) begin : scoreboard
    exp_word_t e;
    if (!arst_n) begin
      held     = 1'b0;
      in_frame = 1'b0;
    end else begin
      // Stalled word must hold
      if (held) begin
        check_true(tx_valid && held_bundle == {tx_data, tx_sop, tx_eop, tx_src_port,
                   tx_dst_port, tx_tc, tx_action}, "tx word changed while stalled");
      end
      if (tx_valid && tx_ready) begin
        words_checked++;
        if (tx_src_port >= NUM_PORTS || exp_q[tx_src_port].size() == 0) begin
          check_true(1'b0, $sformatf("unexpected word from source port %0d", tx_src_port));
        end else begin
          e = exp_q[tx_src_port].pop_front();
          check_value("tx_data", tx_data, e.w.data);
          check_value("tx_sop", tx_sop, e.w.sop);
          check_value("tx_eop", tx_eop, e.w.eop);
          check_value("tx_dst_port", tx_dst_port, e.v.dst);
          check_value("tx_tc", tx_tc, e.v.tc);
          check_value("tx_action", tx_action, e.v.action);
        end
        // No interleaving between sop and eop
        if (tx_sop) begin
          check_true(!in_frame, "sop inside an open frame");
          in_frame  = 1'b1;
          frame_src = tx_src_port;
        end else begin
          check_true(in_frame && tx_src_port == frame_src, "word outside its own frame");
        end
        if (tx_eop) in_frame = 1'b0;
      end
      held        = tx_valid && !tx_ready;
      held_bundle = {tx_data, tx_sop, tx_eop, tx_src_port, tx_dst_port, tx_tc, tx_action};
    end
  end

  // ====================
  // Test sequence
  // ====================
  initial begin
    logic [csr_w-1:0] rd;
    rx_valid = '0;
    rx_sop   = '0;
    rx_eop   = '0;
    rx_data  = '0;
    tx_ready = 1'b1;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    arst_n   = 1'b0;
    repeat (4) @(posedge ingress_clock);
    check_true(rx_ready == '0 && !tx_valid && !wb_ack, "outputs not low after reset");
    arst_n <= 1'b1;

    // Ingress disabled so frames must wait
    @(negedge ingress_clock);
    for (int p = 0; p < NUM_PORTS; p++) send_frame(p, 2, {random_addr(3'(p)), 16'h0800});
    repeat (50) begin
      @(negedge ingress_clock);
      check_true(!tx_valid && rx_ready == '0, "traffic while ingress disabled");
    end
    wb_write(reg_ctrl, 32'h1);
    wait_drain();

    // Unicast from one port with a class map
    wb_write(reg_tc_map, 32'h0000_02e4);
    @(negedge ingress_clock);
    for (int i = 0; i < 6; i++) send_frame(1, frame_len(), {random_addr(3'(i % 5)), 16'h86dd});
    wait_drain();

    // Broadcast, dropped ethertype, invalid destination
    wb_write(reg_drop_etype, 32'h0001_88cc);
    @(negedge ingress_clock);
    send_frame(2, 3, {48'hffff_ffff_ffff, 16'h0800});
    send_frame(3, 2, {random_addr(3'd1), 16'h88cc});
    send_frame(0, 4, {random_addr(3'd6), 16'h0800});
    send_frame(4, 1, {random_addr(3'd3), 16'h0800});
    wait_drain();
    check_counters();

    // All ports at once
    @(negedge ingress_clock);
    for (int p = 0; p < NUM_PORTS; p++) begin
      for (int i = 0; i < 3; i++) send_frame(p, frame_len(), random_first());
    end
    wait_drain();

    // Random back-pressure on tx
    random_ready = 1'b1;
    for (int p = 0; p < NUM_PORTS; p++) begin
      for (int i = 0; i < 4; i++) send_frame(p, frame_len(), random_first());
    end
    wait_drain();
    random_ready = 1'b0;
    repeat (4) @(negedge ingress_clock);

    // Register readback with unused addresses reading zero
    wb_read(reg_ctrl, rd);
    check_value("reg_ctrl", rd, sh_ctrl & 32'h1);
    wb_read(reg_drop_etype, rd);
    check_value("reg_drop_etype", rd, sh_drop & 32'h1_ffff);
    wb_read(reg_tc_map, rd);
    check_value("reg_tc_map", rd, sh_tc & 32'h3ff);
    for (int a = 5; a < 8; a++) begin
      wb_read(3'(a), rd);
      check_value($sformatf("wb_dat_r at address %0d", a), rd, 0);
    end
    check_counters();

    $display("Checked %0d words, %0d mismatches, %0d other errors",
             words_checked, mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* sim.f */
hw/igr_types_pkg.sv
hw/igr_csr_pkg.sv
hw/igr_port_arb.sv
hw/igr_parser.sv
hw/igr_classifier.sv
hw/igr_csr.sv
hw/igr_top.sv
verif/igr_tb.sv
